/* design/pitaya_pkg.sv */
package pitaya_pkg;

  ////////////////////////////////////////
  // widths and depths
  ////////////////////////////////////////
  localparam int ADC_PIN_W  = 16;  // pins per ADC channel, 2 lsb reserved
  localparam int SAMPLE_W   = 14;
  localparam int SYS_W      = 32;  // bus addr/data
  localparam int REGION_LSB = 20;
  localparam int REGION_W   = 3;
  localparam int N_REGIONS  = 8;
  localparam int FIFO_DEPTH = 16;  // sample pairs
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  localparam int LEVEL_W    = 5;   // holds 0..FIFO_DEPTH
  localparam int DROP_W     = 16;
  localparam int LED_W      = 8;

  ////////////////////////////////////////
  // region 0 register map
  ////////////////////////////////////////
  localparam logic [REGION_LSB-1:0] REG_CTRL   = 'h0;
  localparam logic [REGION_LSB-1:0] REG_LED    = 'h4;
  localparam logic [REGION_LSB-1:0] REG_STATUS = 'h8;

  localparam int CTRL_LOOP_BIT   = 0;
  localparam int CTRL_DAC_EN_BIT = 1;

  typedef logic signed [SAMPLE_W-1:0] sample_t;

  typedef struct packed {
    sample_t a;  // channel a
    sample_t b;  // channel b
  } sample_pair_t;

  typedef struct packed {
    logic [SAMPLE_W-1:0] a;
    logic [SAMPLE_W-1:0] b;
  } dac_code_t;

  typedef struct packed {
    logic [SYS_W-1:0] addr;
    logic [SYS_W-1:0] wdata;
    logic             wen;
    logic             ren;
  } sys_req_t;

  typedef struct packed {
    logic [SYS_W-1:0] rdata;
    logic             ack;
    logic             err;
  } sys_rsp_t;

  // negative slope code <-> two's complement, same bit flip both ways
  function automatic logic [SAMPLE_W-1:0] neg_slope(input logic [SAMPLE_W-1:0] code);
    return {code[SAMPLE_W-1], ~code[SAMPLE_W-2:0]};
  endfunction

endpackage

/* design/adc_frontend.sv */
`timescale 1ns/1ps

module adc_frontend (
  input  logic                                 adc_clk,
  input  logic                                 arst_n_i,
  input  logic [pitaya_pkg::ADC_PIN_W-1:0]     adc_dat_a_i,   // ch a pins
  input  logic [pitaya_pkg::ADC_PIN_W-1:0]     adc_dat_b_i,   // ch b pins
  input  logic                                 digital_loop_i,
  input  pitaya_pkg::sample_pair_t             dac_pair_i,    // from dac side
  output logic                                 valid_o,
  output pitaya_pkg::sample_pair_t             pair_o,
  input  logic                                 ready_i,
  output logic [pitaya_pkg::DROP_W-1:0]        drop_count_o
);

  import pitaya_pkg::*;

  logic [SAMPLE_W-1:0] adc_dat_a_q;
  logic [SAMPLE_W-1:0] adc_dat_b_q;
  logic                valid_q;
  logic [DROP_W-1:0]   drop_q;
  sample_pair_t        adc_pair;

  ////////////////////////////////////////
  // input register
  ////////////////////////////////////////

  // upper bits only, the two lsb are reserved
  always_ff @(posedge adc_clk)
  begin
    adc_dat_a_q <= adc_dat_a_i[ADC_PIN_W-1 -: SAMPLE_W];
    adc_dat_b_q <= adc_dat_b_i[ADC_PIN_W-1 -: SAMPLE_W];
  end

  // adc never stalls, valid from first cycle after reset
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      valid_q <= 1'b0;
    else
      valid_q <= 1'b1;
  end

  // unsigned neg slope -> two's complement
  assign adc_pair.a = sample_t'(neg_slope(adc_dat_a_q));
  assign adc_pair.b = sample_t'(neg_slope(adc_dat_b_q));

  assign pair_o  = digital_loop_i ? dac_pair_i : adc_pair;  // loopback switch
  assign valid_o = valid_q;

  ////////////////////////////////////////
  // lost pairs, saturating
  ////////////////////////////////////////
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      drop_q <= '0;
    else if (valid_q && !ready_i && (drop_q != '1))
      drop_q <= drop_q + 1'b1;
  end

  assign drop_count_o = drop_q;

endmodule

/* design/sample_fifo.sv */
`timescale 1ns/1ps

module sample_fifo (
  input  logic                            adc_clk,
  input  logic                            arst_n_i,
  input  logic                            in_valid_i,
  input  pitaya_pkg::sample_pair_t        in_pair_i,
  output logic                            in_ready_o,
  output logic                            out_valid_o,
  output pitaya_pkg::sample_pair_t        out_pair_o,
  input  logic                            out_ready_i,
  output logic [pitaya_pkg::LEVEL_W-1:0]  level_o       // pairs held, incl. output reg
);

  import pitaya_pkg::*;

  sample_pair_t       mem [FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [LEVEL_W-1:0] level_q;
  logic               out_valid_q;
  sample_pair_t       out_pair_q;
  logic               push;
  logic               pop;
  logic               mem_empty;
  logic               load_out;   // output register takes a new pair
  logic               bypass;     // empty: input goes straight to output reg

  assign push      = in_valid_i & in_ready_o;
  assign pop       = out_valid_q & out_ready_i;
  // output reg is always filled first, so mem never holds all FIFO_DEPTH
  assign mem_empty = (wr_ptr == rd_ptr);
  assign load_out  = !out_valid_q || pop;
  assign bypass    = load_out && mem_empty;

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (push && !bypass)
      mem[wr_ptr] <= in_pair_i;
    if (load_out)
      out_pair_q <= mem_empty ? in_pair_i : mem[rd_ptr];
  end

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      out_valid_q <= 1'b0;
    end
    else
    begin
      if (push && !bypass)
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (load_out)
      begin
        if (!mem_empty)
        begin
          rd_ptr      <= rd_ptr + 1'b1;
          out_valid_q <= 1'b1;
        end
        else
          out_valid_q <= push;  // bypass or run dry
      end
    end
  end

  ////////////////////////////////////////
  // fill level
  ////////////////////////////////////////
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      level_q <= '0;
    else
    begin
      case ({push, pop})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;  // none or both
      endcase
    end
  end

  assign in_ready_o  = (level_q != LEVEL_W'(FIFO_DEPTH));  // low only when full
  assign out_valid_o = out_valid_q;
  assign out_pair_o  = out_pair_q;
  assign level_o     = level_q;

endmodule

/* design/dac_backend.sv */
`timescale 1ns/1ps

module dac_backend (
  input  logic                      adc_clk,
  input  logic                      arst_n_i,
  input  logic                      dac_en_i,
  input  logic                      in_valid_i,
  input  pitaya_pkg::sample_pair_t  in_pair_i,
  output logic                      in_ready_o,
  output pitaya_pkg::dac_code_t     dac_o,       // neg slope codes to pins
  output pitaya_pkg::sample_pair_t  dac_pair_o   // signed, back to loopback
);

  import pitaya_pkg::*;

  dac_code_t    dac_q;
  sample_pair_t pair_q;
  logic         take;

  assign in_ready_o = dac_en_i;  // pops whenever enabled
  assign take       = in_valid_i & dac_en_i;

  ////////////////////////////////////////
  // output registers
  ////////////////////////////////////////

  // hold last value while fifo empty or disabled
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dac_q  <= '0;
      pair_q <= '0;
    end
    else if (take)
    begin
      pair_q  <= in_pair_i;
      dac_q.a <= neg_slope(in_pair_i.a);  // signed -> neg slope offset
      dac_q.b <= neg_slope(in_pair_i.b);
    end
  end

  assign dac_o      = dac_q;
  assign dac_pair_o = pair_q;

endmodule

/* design/sys_regs.sv */
`timescale 1ns/1ps

module sys_regs (
  input  logic                            adc_clk,
  input  logic                            arst_n_i,
  input  pitaya_pkg::sys_req_t            sys_req_i,
  output pitaya_pkg::sys_rsp_t            sys_rsp_o,
  input  logic [pitaya_pkg::LEVEL_W-1:0]  fifo_level_i,
  input  logic [pitaya_pkg::DROP_W-1:0]   drop_count_i,
  output logic                            digital_loop_o,
  output logic                            dac_en_o,
  output logic [pitaya_pkg::LED_W-1:0]    led_o
);

  import pitaya_pkg::*;

  logic [REGION_W-1:0]   region;
  logic                  region0;       // request hits the register block
  logic [REGION_LSB-1:0] offset;        // byte offset inside region
  logic [SYS_W-1:0]      reg0_rdata;
  logic                  loop_q;
  logic                  dac_en_q;
  logic [LED_W-1:0]      led_q;
  logic                  ack_q;
  logic [SYS_W-1:0]      rdata_q;

  ////////////////////////////////////////
  // region decode
  ////////////////////////////////////////
  assign region  = sys_req_i.addr[REGION_LSB +: REGION_W];
  assign region0 = (region == '0);
  assign offset  = sys_req_i.addr[REGION_LSB-1:0];

  // region 0 read word
  always_comb
  begin
    reg0_rdata = '0;
    case (offset)
      REG_CTRL:
      begin
        reg0_rdata[CTRL_LOOP_BIT]   = loop_q;
        reg0_rdata[CTRL_DAC_EN_BIT] = dac_en_q;
      end
      REG_LED:    reg0_rdata[LED_W-1:0] = led_q;
      REG_STATUS:
      begin
        reg0_rdata[LEVEL_W-1:0]          = fifo_level_i;
        reg0_rdata[SYS_W-1 -: DROP_W]    = drop_count_i;  // bits 31:16
      end
      default:    reg0_rdata = '0;
    endcase
  end

  ////////////////////////////////////////
  // region 0 registers
  ////////////////////////////////////////
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      loop_q   <= 1'b0;
      dac_en_q <= 1'b0;
      led_q    <= '0;
    end
    else if (sys_req_i.wen && region0)
    begin
      case (offset)
        REG_CTRL:
        begin
          loop_q   <= sys_req_i.wdata[CTRL_LOOP_BIT];
          dac_en_q <= sys_req_i.wdata[CTRL_DAC_EN_BIT];
        end
        REG_LED: led_q <= sys_req_i.wdata[LED_W-1:0];
        default: ;  // status is read only
      endcase
    end
  end

  // every region answers one cycle after the request
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ack_q   <= 1'b0;
      rdata_q <= '0;
    end
    else
    begin
      ack_q   <= sys_req_i.wen | sys_req_i.ren;
      rdata_q <= region0 ? reg0_rdata : '0;  // regions 1..7 read zero
    end
  end

  assign sys_rsp_o.rdata = rdata_q;
  assign sys_rsp_o.ack   = ack_q;
  assign sys_rsp_o.err   = 1'b0;  // no error source

  assign digital_loop_o = loop_q;
  assign dac_en_o       = dac_en_q;
  assign led_o          = led_q;

endmodule

/* design/pitaya_top.sv */
`timescale 1ns/1ps

module pitaya_top (
  input  logic                              adc_clk,
  input  logic                              arst_n_i,
  input  logic [pitaya_pkg::ADC_PIN_W-1:0]  adc_dat_a_i,
  input  logic [pitaya_pkg::ADC_PIN_W-1:0]  adc_dat_b_i,
  input  pitaya_pkg::sys_req_t              sys_req_i,
  output pitaya_pkg::sys_rsp_t              sys_rsp_o,
  output pitaya_pkg::dac_code_t             dac_o,
  output logic [pitaya_pkg::LED_W-1:0]      led_o
);

  import pitaya_pkg::*;

  // adc -> fifo
  logic               frontend_valid;
  sample_pair_t       frontend_pair;
  logic               fifo_ready;
  // fifo -> dac
  logic               out_valid;
  sample_pair_t       out_pair;
  logic               out_ready;
  // config and status
  logic               digital_loop;
  logic               dac_en;
  logic [LEVEL_W-1:0] fifo_level;
  logic [DROP_W-1:0]  drop_count;
  sample_pair_t       dac_pair;     // loopback path

  ////////////////////////////////////////
  // sample path
  ////////////////////////////////////////
  adc_frontend u_adc_frontend (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .dac_pair_i     (dac_pair),
    .valid_o        (frontend_valid),
    .pair_o         (frontend_pair),
    .ready_i        (fifo_ready),
    .drop_count_o   (drop_count)
  );

  sample_fifo u_sample_fifo (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (frontend_valid),
    .in_pair_i   (frontend_pair),
    .in_ready_o  (fifo_ready),
    .out_valid_o (out_valid),
    .out_pair_o  (out_pair),
    .out_ready_i (out_ready),
    .level_o     (fifo_level)
  );

  dac_backend u_dac_backend (
    .adc_clk    (adc_clk),
    .arst_n_i   (arst_n_i),
    .dac_en_i   (dac_en),
    .in_valid_i (out_valid),
    .in_pair_i  (out_pair),
    .in_ready_o (out_ready),
    .dac_o      (dac_o),
    .dac_pair_o (dac_pair)
  );

  ////////////////////////////////////////
  // system bus
  ////////////////////////////////////////
  sys_regs u_sys_regs (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .sys_req_i      (sys_req_i),
    .sys_rsp_o      (sys_rsp_o),
    .fifo_level_i   (fifo_level),
    .drop_count_i   (drop_count),
    .digital_loop_o (digital_loop),
    .dac_en_o       (dac_en),
    .led_o          (led_o)
  );

endmodule

/* tests/tb_pitaya_top.sv */
`timescale 1ns/1ps

module tb_pitaya_top;

  import pitaya_pkg::*;

  localparam int MODE_IDLE   = 0;  // dac changes not checked
  localparam int MODE_STRICT = 1;  // every driven word, in order
  localparam int MODE_SUBSEQ = 2;  // words may be dropped, order kept
  localparam int MODE_LOOP   = 3;  // no fresh adc codes on the dac
  // tests take about 1100 cycles
  localparam int MAX_CYCLES  = 4000;

  logic                 adc_clk;
  logic                 arst_n_i;
  logic [ADC_PIN_W-1:0] adc_dat_a_i;
  logic [ADC_PIN_W-1:0] adc_dat_b_i;
  sys_req_t             sys_req_i;
  sys_rsp_t             sys_rsp_o;
  dac_code_t            dac_o;
  logic [LED_W-1:0]     led_o;

  integer            seed = 12;
  int                mode;
  logic              adc_run;     // driver puts a new random word on the pins
  int                cycles;
  int                err_value;   // wrong values
  int                err_other;   // protocol and ordering failures
  logic [31:0]       word;
  dac_code_t         code;
  dac_code_t         last_dac;
  dac_code_t         head;
  logic              found;
  logic [SYS_W-1:0]  rdata;
  logic [DROP_W-1:0] drops_before;  // drop count before back-pressure
  dac_code_t         exp_q  [$];  // expected codes of driven words
  dac_code_t         post_q [$];  // codes driven after loopback on
  dac_code_t         seen_q [$];  // every dac value observed

  pitaya_top u_pitaya_top (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .sys_req_i   (sys_req_i),
    .sys_rsp_o   (sys_rsp_o),
    .dac_o       (dac_o),
    .led_o       (led_o)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk;  // 50 MHz
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // pins {a[15:0], b[15:0]} with the low two bits reserved
  function automatic sample_pair_t adc_to_sample(input logic [31:0] pins);
    logic [SAMPLE_W-1:0] a;
    logic [SAMPLE_W-1:0] b;
    sample_pair_t        p;
    a   = pins[31 -: SAMPLE_W];
    b   = pins[15 -: SAMPLE_W];
    p.a = {a[SAMPLE_W-1], ~a[SAMPLE_W-2:0]};  // msb kept, rest flipped
    p.b = {b[SAMPLE_W-1], ~b[SAMPLE_W-2:0]};
    return p;
  endfunction

  function automatic dac_code_t sample_to_dac(input sample_pair_t p);
    dac_code_t d;
    d.a = {p.a[SAMPLE_W-1], ~p.a[SAMPLE_W-2:0]};
    d.b = {p.b[SAMPLE_W-1], ~p.b[SAMPLE_W-2:0]};
    return d;
  endfunction

  function automatic bit in_post(input dac_code_t v);
    foreach (post_q[i])
      if (post_q[i] == v)
        return 1'b1;
    return 1'b0;
  endfunction

  function automatic bit in_seen(input dac_code_t v);
    foreach (seen_q[i])
      if (seen_q[i] == v)
        return 1'b1;
    return 1'b0;
  endfunction

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////
  task automatic check_dac(input string name, input dac_code_t exp, input dac_code_t act);
    if (act !== exp)
    begin
      err_value++;
      $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input logic [SYS_W-1:0] exp,
                            input logic [SYS_W-1:0] act);
    if (act !== exp)
    begin
      err_value++;
      $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_led(input string name, input logic [LED_W-1:0] exp,
                           input logic [LED_W-1:0] act);
    if (act !== exp)
    begin
      err_value++;
      $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  ////////////////////////////////////////
  // bus tasks
  ////////////////////////////////////////

  // one ack within 4 cycles, none on the cycle after it
  task automatic await_ack(input logic [SYS_W-1:0] addr, output logic [SYS_W-1:0] data);
    logic got;
    got  = 1'b0;
    data = '0;
    for (int n = 0; n < 4 && !got; n++)
    begin
      @(negedge adc_clk);
      if (sys_rsp_o.ack)
      begin
        got  = 1'b1;
        data = sys_rsp_o.rdata;  // valid with ack
        if (sys_rsp_o.err !== 1'b0)
        begin
          err_value++;
          $display("ERR t=%0t sys_rsp_o.err expected 0 actual %b", $time, sys_rsp_o.err);
        end
      end
    end
    if (!got)
    begin
      err_other++;
      $display("bus request to %h got no ack within 4 cycles", addr);
    end
    else
    begin
      @(negedge adc_clk);
      if (sys_rsp_o.ack)
      begin
        err_other++;
        $display("bus request to %h was acknowledged more than once", addr);
      end
    end
  endtask

  task automatic bus_write(input logic [SYS_W-1:0] addr, input logic [SYS_W-1:0] data);
    sys_req_t         req;
    logic [SYS_W-1:0] unused;
    req       = '0;
    req.addr  = addr;
    req.wdata = data;
    req.wen   = 1'b1;
    @(posedge adc_clk);
    sys_req_i <= req;
    @(posedge adc_clk);
    sys_req_i <= '0;  // one cycle pulse
    await_ack(addr, unused);
  endtask

  task automatic bus_read(input logic [SYS_W-1:0] addr, output logic [SYS_W-1:0] data);
    sys_req_t req;
    req      = '0;
    req.addr = addr;
    req.ren  = 1'b1;
    @(posedge adc_clk);
    sys_req_i <= req;
    @(posedge adc_clk);
    sys_req_i <= '0;
    await_ack(addr, data);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge adc_clk);
  endtask

  // waits until the dac has shown the last driven word
  task automatic drain_expected(input string phase);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 4 * FIFO_DEPTH)
    begin
      @(negedge adc_clk);
      n++;
    end
    if (exp_q.size() != 0)
    begin
      err_other++;
      $display("%s: %0d driven words never reached the DAC", phase, exp_q.size());
    end
    exp_q.delete();
  endtask

  ////////////////////////////////////////
  // adc driver and dac checker
  ////////////////////////////////////////
  always @(posedge adc_clk)
  begin
    if (adc_run)
    begin
      word = $random(seed);
      adc_dat_a_i <= word[31:16];
      adc_dat_b_i <= word[15:0];
      code = sample_to_dac(adc_to_sample(word));
      if (mode == MODE_LOOP)
        post_q.push_back(code);
      else
        exp_q.push_back(code);
    end
  end

  // dac settles after the edge, look at it on the falling edge
  always @(negedge adc_clk)
  begin
    if (arst_n_i && (dac_o !== last_dac))
    begin
      case (mode)
        MODE_STRICT:
        begin
          while (exp_q.size() > 0 && exp_q[0] == last_dac)
            head = exp_q.pop_front();  // repeated code makes no visible change
          if (exp_q.size() == 0)
          begin
            err_other++;
            $display("dac_o changed at %0t with no driven word pending", $time);
          end
          else
          begin
            head = exp_q.pop_front();
            check_dac("dac_o", head, dac_o);
          end
        end
        MODE_SUBSEQ:
        begin
          found = 1'b0;
          while (!found && exp_q.size() > 0)
          begin
            head  = exp_q.pop_front();  // skipped words were dropped
            found = (head == dac_o);
          end
          if (!found)
          begin
            err_other++;
            $display("dac_o %h at %0t is out of order or was never driven", dac_o, $time);
          end
        end
        MODE_LOOP:
        begin
          if (in_post(dac_o) && !in_seen(dac_o))
          begin
            err_other++;
            $display("dac_o %h at %0t came from the adc while loopback was on",
                     dac_o, $time);
          end
        end
        default: ;
      endcase
      seen_q.push_back(dac_o);
      last_dac = dac_o;
    end
  end

  always @(posedge adc_clk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////
  initial
  begin
    arst_n_i    = 1'b0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    sys_req_i   = '0;
    adc_run     = 1'b0;
    mode        = MODE_IDLE;
    cycles      = 0;
    err_value   = 0;
    err_other   = 0;
    last_dac    = '0;
    repeat (3) @(posedge adc_clk);
    arst_n_i <= 1'b1;
    wait_cycles(2);

    // region 0 registers
    bus_write(REG_LED, 'hA5);
    bus_read(REG_LED, rdata);
    check_word("sys_rsp_o.rdata", 'hA5, rdata);
    check_led("led_o", 8'hA5, led_o);
    bus_write(REG_LED, 'h3C);
    check_led("led_o", 8'h3C, led_o);
    bus_write(REG_CTRL, 'h1 << CTRL_DAC_EN_BIT);
    bus_read(REG_CTRL, rdata);
    check_word("sys_rsp_o.rdata", 'h2, rdata);
    bus_write(REG_CTRL, 'h0);
    bus_read(REG_CTRL, rdata);
    check_word("sys_rsp_o.rdata", 'h0, rdata);

    // writes to regions 1..7 must not reach region 0
    for (int r = 1; r < N_REGIONS; r++)
    begin
      bus_write(SYS_W'(r << REGION_LSB) | REG_CTRL, '1);
      bus_write(SYS_W'(r << REGION_LSB) | REG_LED, '1);
      bus_read(SYS_W'(r << REGION_LSB) | REG_CTRL, rdata);
      check_word("sys_rsp_o.rdata", '0, rdata);
      bus_read(SYS_W'(r << REGION_LSB) | REG_STATUS, rdata);
      check_word("sys_rsp_o.rdata", '0, rdata);
    end
    bus_read(REG_CTRL, rdata);
    check_word("sys_rsp_o.rdata", 'h0, rdata);
    bus_read(REG_LED, rdata);
    check_word("sys_rsp_o.rdata", 'h3C, rdata);
    check_led("led_o", 8'h3C, led_o);

    // pass-through while the fifo never fills
    bus_write(REG_CTRL, 'h2);
    wait_cycles(20);  // fifo now pops one pair per push
    mode    = MODE_STRICT;
    adc_run = 1'b1;
    wait_cycles(400);
    adc_run = 1'b0;
    drain_expected("pass-through");
    bus_read(REG_STATUS, rdata);
    drops_before = rdata[SYS_W-1 -: DROP_W];

    // back-pressure
    mode    = MODE_SUBSEQ;
    adc_run = 1'b1;
    bus_write(REG_CTRL, 'h0);
    wait_cycles(100);
    bus_read(REG_STATUS, rdata);
    check_word("sys_rsp_o.rdata[15:0]", SYS_W'(FIFO_DEPTH), rdata & SYS_W'(16'hFFFF));
    if (rdata[SYS_W-1 -: DROP_W] <= drops_before)
    begin
      err_other++;
      $display("drop count did not grow while the FIFO was full");
    end
    bus_write(REG_CTRL, 'h2);
    wait_cycles(100);
    adc_run = 1'b0;
    drain_expected("back-pressure");

    // loopback where the dac recirculates old samples
    adc_run = 1'b1;
    bus_write(REG_CTRL, 'h3);
    mode = MODE_LOOP;  // only words driven from here on are marked
    wait_cycles(200);
    adc_run = 1'b0;
    bus_write(REG_CTRL, 'h0);
    mode = MODE_IDLE;
    exp_q.delete();

    $display("errors: %0d value mismatches, %0d other failures", err_value, err_other);
    if (err_value + err_other == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

/* verilog.f */
design/pitaya_pkg.sv
design/adc_frontend.sv
design/sample_fifo.sv
design/dac_backend.sv
design/sys_regs.sv
design/pitaya_top.sv
tests/tb_pitaya_top.sv

/* Bender.yml */
package:
  name: pitaya_top

sources:
  - files:
      - design/pitaya_pkg.sv
      - design/adc_frontend.sv
      - design/sample_fifo.sv
      - design/dac_backend.sv
      - design/sys_regs.sv
      - design/pitaya_top.sv
  - target: test
    files:
      - tests/tb_pitaya_top.sv
